//--- rtl/lb_test_pkg.sv
/*
 * Shared definitions for the connector loopback test engine.
 * LANE_PINS is fixed at 8, so a connector with fewer loop pairs must tie
 * its spare B pins to the matching A pins.
 */
package lb_test_pkg;

   localparam int LANE_PINS = 8;                   // Loop pairs per connector

   typedef logic [LANE_PINS-1:0] pin_vec_t;        // One side of one connector

   // Alternating patterns, each pin sees both levels and neighbours differ
   localparam pin_vec_t PAT_A = 8'hAA;             // First pass
   localparam pin_vec_t PAT_B = 8'h55;             // Inverse pass

   typedef logic [7:0] settle_cnt_t;               // Settle window length, 1 to 255
   typedef logic [7:0] err_cnt_t;                  // Failing pins over all lanes

   // Sequencer FSM
   typedef enum logic [2:0] {
      S_IDLE     = 3'd0,                           // Drivers off, waiting for run
      S_SETTLE_A = 3'd1,                           // Driving PAT_A, cable settling
      S_CHECK_A  = 3'd2,                           // Compare against PAT_A
      S_SETTLE_B = 3'd3,                           // Driving PAT_B, cable settling
      S_CHECK_B  = 3'd4,                           // Compare against PAT_B
      S_DONE     = 3'd5                            // Drivers off, result posted
   } seq_state_t;

endpackage

//--- rtl/lb_sequencer.sv
/*
 * Single FSM that decides when any lane may drive its A-side pins.
 * Strobes are decoded from state and gated by run, so dropping run turns
 * the drivers off at the very next edge. SETTLE_CYCLES must be 1 or more.
 * Done appears 2*SETTLE_CYCLES+5 edges after run is first seen in idle.
 */
module lb_sequencer #(
   parameter lb_test_pkg::settle_cnt_t SETTLE_CYCLES = 8'd16
) (
   input  logic clk,
   input  logic rst_n,
   input  logic run,
   output logic drive_en,      // Level, A-side drivers on
   output logic pat_sel,       // Level, 0 selects PAT_A, 1 selects PAT_B
   output logic clear,         // Pulse, zero the sticky error bits
   output logic check,         // Pulse, compare B side to driven pattern
   output logic finish         // Pulse, collector latches the result
);
   import lb_test_pkg::*;

   seq_state_t  state;
   settle_cnt_t cnt;           // Settle down-counter, reused as a drain count in S_DONE

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= S_IDLE;
         cnt   <= '0;
      end else if (!run) begin
         state <= S_IDLE;      // Abort from anywhere
         cnt   <= '0;
      end else begin
         case (state)
            S_IDLE: begin
               state <= S_SETTLE_A;
               cnt   <= SETTLE_CYCLES;         // One extra cycle for the clear strobe
            end
            S_SETTLE_A: begin
               if (cnt == '0) begin
                  state <= S_CHECK_A;
               end else begin
                  cnt <= settle_cnt_t'(cnt - 1'b1);
               end
            end
            S_CHECK_A: begin
               state <= S_SETTLE_B;
               cnt   <= settle_cnt_t'(SETTLE_CYCLES - 1'b1);
            end
            S_SETTLE_B: begin
               if (cnt == '0) begin
                  state <= S_CHECK_B;
               end else begin
                  cnt <= settle_cnt_t'(cnt - 1'b1);
               end
            end
            S_CHECK_B: begin
               state <= S_DONE;
               cnt   <= settle_cnt_t'(2);      // Let the lanes release the pins first
            end
            S_DONE: begin
               if (cnt != '0) begin
                  cnt <= settle_cnt_t'(cnt - 1'b1);
               end                             // Park here until run falls
            end
            default: begin
               state <= S_IDLE;
               cnt   <= '0;
            end
         endcase
      end
   end

   // Strobe decode, nothing is asserted while run is low
   always_comb begin
      drive_en = 1'b0;
      pat_sel  = 1'b0;
      clear    = 1'b0;
      check    = 1'b0;
      finish   = 1'b0;
      if (run) begin
         case (state)
            S_SETTLE_A: begin
               drive_en = 1'b1;
               clear    = (cnt == SETTLE_CYCLES);  // First cycle of the test only
            end
            S_CHECK_A: begin
               drive_en = 1'b1;
               pat_sel  = 1'b1;        // Lane compares with PAT_A, then loads PAT_B
               check    = 1'b1;
            end
            S_SETTLE_B: begin
               drive_en = 1'b1;
               pat_sel  = 1'b1;
            end
            S_CHECK_B: begin
               drive_en = 1'b1;        // Held through the last compare
               pat_sel  = 1'b1;
               check    = 1'b1;
            end
            S_DONE: begin
               finish = (cnt == settle_cnt_t'(1));  // Single pulse, a_oe already low
            end
            default: begin
               drive_en = 1'b0;        // Idle keeps everything off
            end
         endcase
      end
   end

endmodule

//--- rtl/lb_connector_lane.sv
/*
 * One connector. A side is registered pattern plus output enable, the pad
 * tristate buffer sits in the chip top. B side is registered once, so the
 * settle window must cover cable delay plus that one register stage.
 */
module lb_connector_lane (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  drive_en,
   input  logic                  pat_sel,
   input  logic                  clear,
   input  logic                  check,
   input  lb_test_pkg::pin_vec_t b_in,        // Loopback returns, input only
   output lb_test_pkg::pin_vec_t a_out,       // Pad output value
   output logic                  a_oe,        // Pad output enable, same for all pins
   output lb_test_pkg::pin_vec_t err_bits     // Sticky per-pin mismatch
);
   import lb_test_pkg::*;

   pin_vec_t pat_next;         // Pattern for the coming cycle
   pin_vec_t pat_q;            // Pattern on the pins now
   pin_vec_t b_q;              // Registered B side
   pin_vec_t diff;             // Pins that disagree with the pattern

   always_comb begin
      if (!drive_en) begin
         pat_next = '0;        // Park low when not driving
      end else if (pat_sel) begin
         pat_next = PAT_B;
      end else begin
         pat_next = PAT_A;
      end
   end

   // Pattern and B-side sample
   always_ff @(posedge clk) begin
      pat_q <= pat_next;
      b_q   <= b_in;           // Asynchronous to us until here
   end

   assign a_out = pat_q;
   assign diff  = b_q ^ pat_q; // Compared against the pattern still driven

   // Enable and error accumulator
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_oe     <= 1'b0;     // Pins safe out of reset
         err_bits <= '0;
      end else begin
         a_oe <= drive_en;
         if (clear) begin
            err_bits <= '0;    // New test
         end else if (check) begin
            err_bits <= err_bits | diff;  // Sticky over both passes
         end
      end
   end

endmodule

//--- rtl/lb_result_collect.sv
/*
 * Posts the result of one test. status bit L*LANE_PINS+i is pin i of lane L.
 * err_count is 8 bits, which holds for up to 31 lanes.
 * Everything here clears on the edge after run falls.
 */
module lb_result_collect #(
   parameter int NUM_LANES = 2
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          run,
   input  logic                                          finish,
   input  logic [NUM_LANES*lb_test_pkg::LANE_PINS-1:0]   lane_err,
   output logic [NUM_LANES*lb_test_pkg::LANE_PINS-1:0]   status,
   output lb_test_pkg::err_cnt_t                         err_count,
   output logic                                          done
);
   import lb_test_pkg::*;

   localparam int TOTAL_PINS = NUM_LANES * LANE_PINS;

   err_cnt_t fail_cnt;         // Population count of lane_err

   always_comb begin
      fail_cnt = '0;
      for (int i = 0; i < TOTAL_PINS; i++) begin
         fail_cnt = err_cnt_t'(fail_cnt + err_cnt_t'(lane_err[i]));
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status    <= '0;
         err_count <= '0;
         done      <= 1'b0;
      end else if (!run) begin
         status    <= '0;      // Abort or end of test
         err_count <= '0;
         done      <= 1'b0;
      end else if (finish) begin
         status    <= lane_err;  // Lanes stable since the last check
         err_count <= fail_cnt;
         done      <= 1'b1;      // Held until run falls
      end
   end

endmodule

//--- rtl/lb_test_top.sv
/*
 * Loopback test engine for NUM_LANES connectors. Exposes per-pin value and
 * per-connector enable, the chip top builds the pads. Lane L owns
 * a_out/b_in bits L*LANE_PINS up to L*LANE_PINS+LANE_PINS-1.
 * run is a level, done is a level held until run falls.
 */
module lb_test_top #(
   parameter int                       NUM_LANES     = 2,
   parameter lb_test_pkg::settle_cnt_t SETTLE_CYCLES = 8'd16
) (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          run,
   input  logic [NUM_LANES*lb_test_pkg::LANE_PINS-1:0]   b_in,
   output logic [NUM_LANES*lb_test_pkg::LANE_PINS-1:0]   a_out,
   output logic [NUM_LANES-1:0]                          a_oe,
   output logic [NUM_LANES*lb_test_pkg::LANE_PINS-1:0]   status,
   output lb_test_pkg::err_cnt_t                         err_count,
   output logic                                          done
);
   import lb_test_pkg::*;

   logic                              drive_en;
   logic                              pat_sel;
   logic                              clear;
   logic                              check;
   logic                              finish;
   logic [NUM_LANES*LANE_PINS-1:0]    lane_err;   // All lanes' sticky bits

   // One sequencer for every connector, all switch together
   lb_sequencer #(
      .SETTLE_CYCLES (SETTLE_CYCLES)
   ) u_seq (
      .clk      (clk),
      .rst_n    (rst_n),
      .run      (run),
      .drive_en (drive_en),
      .pat_sel  (pat_sel),
      .clear    (clear),
      .check    (check),
      .finish   (finish)
   );

   for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
      lb_connector_lane u_lane (
         .clk      (clk),
         .rst_n    (rst_n),
         .drive_en (drive_en),
         .pat_sel  (pat_sel),
         .clear    (clear),
         .check    (check),
         .b_in     (b_in[l*LANE_PINS +: LANE_PINS]),
         .a_out    (a_out[l*LANE_PINS +: LANE_PINS]),
         .a_oe     (a_oe[l]),
         .err_bits (lane_err[l*LANE_PINS +: LANE_PINS])
      );
   end

   lb_result_collect #(
      .NUM_LANES (NUM_LANES)
   ) u_collect (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .finish    (finish),
      .lane_err  (lane_err),
      .status    (status),
      .err_count (err_count),
      .done      (done)
   );

endmodule

//--- verif/lb_tb_clock.sv
/*
 * Free-running testbench clock, starts low at time 0.
 * PERIOD_NS should be even so both half periods are whole nanoseconds.
 */
module lb_tb_clock #(
   parameter int PERIOD_NS = 10
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;   // Half period per toggle
   end

endmodule

//--- verif/lb_test_tb.sv
/*
 * Directed tests for the loopback test engine, 2 lanes, 16-cycle settle.
 * The cable model pulls undriven B pins low, then applies pair swaps and
 * stuck-at masks in that order. Outputs are sampled on the falling edge.
 */
module lb_test_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import lb_test_pkg::*;

   localparam int          NUM_LANES     = 2;
   localparam settle_cnt_t SETTLE_CYCLES = 8'd16;
   localparam int          TOTAL_PINS    = NUM_LANES * LANE_PINS;
   localparam int          NUM_PAIRS     = TOTAL_PINS / 2;
   localparam int          DONE_LATENCY  = 2 * int'(SETTLE_CYCLES) + 5;  // Edges after run seen
   localparam int          WAIT_LIMIT    = DONE_LATENCY + 20;
   localparam int          NUM_RUNS      = 21;                           // Incl. the aborted one
   localparam int          TIMEOUT_CYCLES = NUM_RUNS * (2 * int'(SETTLE_CYCLES) + 10) + 200;

   logic                  clk;
   logic                  rst_n;
   logic                  run;
   logic [TOTAL_PINS-1:0] b_in;
   logic [TOTAL_PINS-1:0] a_out;
   logic [NUM_LANES-1:0]  a_oe;
   logic [TOTAL_PINS-1:0] status;
   err_cnt_t              err_count;
   logic                  done;

   logic [TOTAL_PINS-1:0] stuck0_mask;      // Cable faults that read 0
   logic [TOTAL_PINS-1:0] stuck1_mask;      // Cable faults that read 1
   logic [NUM_PAIRS-1:0]  swap_mask;        // Pair p crosses pins 2p and 2p+1
   logic                  seen_pat_a;       // PAT_A observed while driving
   logic                  seen_pat_b;
   logic [31:0]           rng_state;
   int                    fail_total = 0;
   int                    cycle_cnt  = 0;

   lb_tb_clock #(.PERIOD_NS(10)) u_clk (.clk(clk));

   lb_test_top #(
      .NUM_LANES     (NUM_LANES),
      .SETTLE_CYCLES (SETTLE_CYCLES)
   ) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .b_in      (b_in),
      .a_out     (a_out),
      .a_oe      (a_oe),
      .status    (status),
      .err_count (err_count),
      .done      (done)
   );

   // Loopback cable with fault injection
   always_comb begin
      logic [TOTAL_PINS-1:0] driven;
      logic [TOTAL_PINS-1:0] crossed;
      for (int i = 0; i < TOTAL_PINS; i++) begin
         driven[i] = a_oe[i / LANE_PINS] ? a_out[i] : 1'b0;   // Pulled low when released
      end
      crossed = driven;
      for (int p = 0; p < NUM_PAIRS; p++) begin
         if (swap_mask[p]) begin
            crossed[2*p]   = driven[2*p+1];
            crossed[2*p+1] = driven[2*p];
         end
      end
      b_in = (crossed & ~stuck0_mask) | stuck1_mask;
   end

   // Run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run stopped after %0d cycles, %0d errors so far", cycle_cnt,
                  fail_total);
         $display(">>> FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Both pins of each crossed pair see the wrong level for both patterns
   function automatic logic [TOTAL_PINS-1:0] swapped_pins(input logic [NUM_PAIRS-1:0] pairs);
      logic [TOTAL_PINS-1:0] bits;
      bits = '0;
      for (int p = 0; p < NUM_PAIRS; p++) begin
         bits[2*p]   = pairs[p];
         bits[2*p+1] = pairs[p];
      end
      return bits;
   endfunction

   task automatic flag_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
      fail_total++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
   endtask

   task automatic flag_problem(input string what);
      fail_total++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   // Everything must read back as idle one edge after run is low
   task automatic check_idle();
      @(posedge clk);
      @(negedge clk);
      if (a_oe !== '0) flag_mismatch("a_oe", 32'(a_oe), 32'd0);
      if (done !== 1'b0) flag_mismatch("done", 32'(done), 32'd0);
      if (status !== '0) flag_mismatch("status", 32'(status), 32'd0);
      if (err_count !== '0) flag_mismatch("err_count", 32'(err_count), 32'd0);
   endtask

   task automatic set_faults(input logic [TOTAL_PINS-1:0] s0,
                             input logic [TOTAL_PINS-1:0] s1,
                             input logic [NUM_PAIRS-1:0]  swp);
      @(posedge clk);
      stuck0_mask <= s0;
      stuck1_mask <= s1;
      swap_mask   <= swp;
   endtask

   // Raise run, wait for done and check the posted result; run stays high
   task automatic run_to_done(input logic [TOTAL_PINS-1:0] exp_status);
      int cycles;
      @(posedge clk);
      run <= 1'b1;
      seen_pat_a = 1'b0;
      seen_pat_b = 1'b0;
      cycles = 0;
      while (done !== 1'b1 && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
         if (a_oe === '1 && a_out === {NUM_LANES{PAT_A}}) seen_pat_a = 1'b1;
         if (a_oe === '1 && a_out === {NUM_LANES{PAT_B}}) seen_pat_b = 1'b1;
      end
      if (done !== 1'b1) begin
         flag_problem("done never rose after run was raised");
      end else begin
         // Run is first seen one edge after it is driven
         if (cycles - 2 != DONE_LATENCY) flag_mismatch("done latency", 32'(cycles - 2),
                                                        32'(DONE_LATENCY));
         if (status !== exp_status) flag_mismatch("status", 32'(status), 32'(exp_status));
         if (err_count !== err_cnt_t'($countones(exp_status)))
            flag_mismatch("err_count", 32'(err_count), 32'($countones(exp_status)));
         if (a_oe !== '0) flag_mismatch("a_oe", 32'(a_oe), 32'd0);   // Released before done
      end
   endtask

   task automatic stop_run();
      @(posedge clk);
      run <= 1'b0;
      check_idle();
   endtask

   task automatic full_run(input logic [TOTAL_PINS-1:0] s0,
                           input logic [TOTAL_PINS-1:0] s1,
                           input logic [NUM_PAIRS-1:0]  swp,
                           input logic [TOTAL_PINS-1:0] exp_status);
      set_faults(s0, s1, swp);
      run_to_done(exp_status);
      stop_run();
   endtask

   task automatic test_reset_idle();
      @(posedge clk);                       // First reset cycle
      @(negedge clk);
      if (a_oe !== '0) flag_mismatch("a_oe", 32'(a_oe), 32'd0);
      if (done !== 1'b0) flag_mismatch("done", 32'(done), 32'd0);
      @(posedge clk);
      rst_n <= 1'b1;                        // Out of reset after two cycles
      repeat (3) @(posedge clk);
      check_idle();
   endtask

   task automatic test_clean_cable();
      full_run('0, '0, '0, '0);
      if (!seen_pat_a) flag_problem("PAT_A never seen on a_out with a_oe high");
      if (!seen_pat_b) flag_problem("PAT_B never seen on a_out with a_oe high");
   endtask

   task automatic test_single_stuck();
      logic [TOTAL_PINS-1:0] m;
      for (int l = 0; l < NUM_LANES; l++) begin
         m = '0;
         m[l*LANE_PINS + 2] = 1'b1;         // Stuck low fails PAT_B
         full_run(m, '0, '0, m);
         m = '0;
         m[l*LANE_PINS + 4] = 1'b1;         // Stuck high fails PAT_A
         full_run('0, m, '0, m);
      end
   endtask

   task automatic test_random_stuck();
      logic [31:0]           r0;
      logic [31:0]           r1;
      logic [TOTAL_PINS-1:0] s0;
      logic [TOTAL_PINS-1:0] s1;
      for (int n = 0; n < 10; n++) begin
         rng_state = xorshift32(rng_state);
         r0 = rng_state;
         rng_state = xorshift32(rng_state);
         r1 = rng_state;
         s0 = r0[15:0] & r0[31:16];         // AND of halves keeps masks sparse
         s1 = r1[15:0] & r1[31:16];
         full_run(s0, s1, '0, s0 | s1);
      end
   endtask

   task automatic test_swap();
      full_run('0, '0, 8'h02, swapped_pins(8'h02));      // One pair on lane 0
      full_run('0, '0, 8'h91, swapped_pins(8'h91));      // Pairs on both lanes
   endtask

   task automatic test_abort();
      set_faults('0, 16'h0010, '0);
      @(posedge clk);
      run <= 1'b1;
      repeat (28) @(negedge clk);           // PAT_B window, pin 4 already flagged
      if (a_oe !== '1) flag_mismatch("a_oe", 32'(a_oe), 32'(2'b11));
      @(posedge clk);
      run <= 1'b0;
      check_idle();
      full_run(16'h0300, '0, '0, 16'h0300);
   endtask

   task automatic test_done_hold();
      set_faults('0, 16'h8001, '0);
      run_to_done(16'h8001);
      repeat (20) begin
         @(negedge clk);
         if (done !== 1'b1) flag_mismatch("done", 32'(done), 32'd1);
         if (status !== 16'h8001) flag_mismatch("status", 32'(status), 32'h8001);
         if (err_count !== 8'd2) flag_mismatch("err_count", 32'(err_count), 32'd2);
      end
      stop_run();
      full_run('0, '0, 8'h20, swapped_pins(8'h20));      // Old bits must be gone
   endtask

   initial begin
      rst_n       = 1'b0;
      run         = 1'b0;
      stuck0_mask = '0;
      stuck1_mask = '0;
      swap_mask   = '0;
      seen_pat_a  = 1'b0;
      seen_pat_b  = 1'b0;
      rng_state   = 32'h17bd;

      test_reset_idle();
      test_clean_cable();
      test_single_stuck();
      test_random_stuck();
      test_swap();
      test_abort();
      test_done_hold();

      $display("Loopback tests finished with %0d errors", fail_total);
      if (fail_total == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- filelist.f
rtl/lb_test_pkg.sv
rtl/lb_sequencer.sv
rtl/lb_connector_lane.sv
rtl/lb_result_collect.sv
rtl/lb_test_top.sv
verif/lb_tb_clock.sv
verif/lb_test_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the loopback test engine testbench with Verilator, runs it and
# scans the log. Exit status is 0 only for a clean run.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -f filelist.f --top-module lb_test_tb -Mdir obj_dir \
   || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vlb_test_tb > "$LOG" 2>&1 ; cat "$LOG"

grep -q '>>> FAIL' "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q '>>> PASS' "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
